// File: rtl/proc_pkg.sv
/*
 shared sizes, instruction field positions and enums for the multicycle core
 import into any module or interface that needs them
*/
package proc_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int c_xlen       = 32;
  localparam int c_nregs      = 32;
  localparam int c_rf_aw      = 5;
  localparam int c_mem_nwords = 4096;
  // word index into the memory, byte address bits 13 to 2
  localparam int c_mem_aw     = 12;

  // first fetch after reset
  localparam logic [c_xlen-1:0] c_reset_vector = 32'h0000_1000;

  // ------------------------------
  // instruction fields
  // ------------------------------
  localparam int c_op_msb  = 31;
  localparam int c_op_lsb  = 26;
  localparam int c_rs_msb  = 25;
  localparam int c_rs_lsb  = 21;
  localparam int c_rt_msb  = 20;
  localparam int c_rt_lsb  = 16;
  localparam int c_rd_msb  = 15;
  localparam int c_rd_lsb  = 11;
  // immediate is sign-extended to c_xlen
  localparam int c_imm_msb = 15;
  localparam int c_imm_lsb = 0;

  // ------------------------------
  // enums
  // ------------------------------
  // any code not listed here executes as a nop
  typedef enum logic [5:0] {
    op_nop   = 6'h00,
    op_addu  = 6'h01,
    op_subu  = 6'h02,
    op_and   = 6'h03,
    op_addiu = 6'h04,
    op_lw    = 6'h05,
    op_sw    = 6'h06,
    op_bne   = 6'h07,
    op_mfc0  = 6'h08,
    op_mtc0  = 6'h09
  } opcode_e;

  typedef enum logic [1:0] {alu_add, alu_sub, alu_and} alu_fn_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_mngr} wb_sel_e;
  typedef enum logic {mem_rd = 1'b0, mem_wr = 1'b1} mem_type_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_wait,
    st_exec,
    st_dmem,
    st_dmem_wait,
    st_mngr_in,
    st_mngr_out
  } ctrl_state_e;

endpackage

// File: rtl/mem_if.sv
/*
 val/rdy memory request and response channel between the core and memory
 one instance per memory port
*/
`timescale 1ns/1ps

interface mem_if import proc_pkg::*; ();

  // request channel
  logic              req_val;
  logic              req_rdy;
  mem_type_e         req_type;
  logic [c_xlen-1:0] req_addr;
  logic [c_xlen-1:0] req_data;

  // response channel, write responses carry no data
  logic              resp_val;
  logic              resp_rdy;
  logic [c_xlen-1:0] resp_data;

  // control unit owns the handshake
  modport ctrl (output req_val, output req_type, output resp_rdy,
                input req_rdy, input resp_val);

  // datapath owns the message fields
  modport dpath (output req_addr, output req_data, input resp_data);

  modport mem (input req_val, input req_type, input req_addr, input req_data,
               input resp_rdy, output req_rdy, output resp_val, output resp_data);

endinterface

// File: rtl/ctrl_if.sv
/*
 control and status signals between the core control unit and its datapath
*/
`timescale 1ns/1ps

interface ctrl_if import proc_pkg::*; ();

  // control unit to datapath
  logic    pc_en;
  logic    pc_sel_br;
  logic    ir_en;
  logic    rf_wen;
  wb_sel_e wb_sel;
  alu_fn_e alu_fn;
  logic    alu_imm;
  logic    dmsg_en;
  logic    mngr_in_en;

  // datapath to control unit
  opcode_e opcode;
  logic    br_taken;

  modport ctrl (output pc_en, pc_sel_br, ir_en, rf_wen, wb_sel, alu_fn, alu_imm,
                output dmsg_en, mngr_in_en, input opcode, br_taken);

  modport dpath (input pc_en, pc_sel_br, ir_en, rf_wen, wb_sel, alu_fn, alu_imm,
                 input dmsg_en, mngr_in_en, output opcode, br_taken);

endinterface

// File: rtl/proc_ctrl.sv
/*
 multicycle control unit, sequences fetch, execute, data memory and manager
 transfers; every wait state leaves only on a completed val/rdy handshake
*/
`timescale 1ns/1ps

module proc_ctrl import proc_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  mem_if.ctrl  imem,
  mem_if.ctrl  dmem,
  ctrl_if.ctrl cif,
  input  logic from_mngr_val,
  output logic from_mngr_rdy,
  output logic to_mngr_val,
  input  logic to_mngr_rdy
);

  ctrl_state_e state;
  ctrl_state_e state_next;
  // mfc0 word already sits in the datapath message register
  logic        mngr_got;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_fetch;
      mngr_got <= 1'b0;
    end
    else
    begin
      state    <= state_next;
      mngr_got <= cif.mngr_in_en | (mngr_got & ~cif.pc_en);
    end
  end

  // ------------------------------
  // next state and decode
  // ------------------------------
  always_comb
  begin
    state_next     = state;
    imem.req_val   = 1'b0;
    imem.req_type  = mem_rd;
    imem.resp_rdy  = 1'b0;
    dmem.req_val   = 1'b0;
    // opcode is held in the IR for the whole data access
    dmem.req_type  = (cif.opcode == op_sw) ? mem_wr : mem_rd;
    dmem.resp_rdy  = 1'b0;
    cif.pc_en      = 1'b0;
    cif.pc_sel_br  = 1'b0;
    cif.ir_en      = 1'b0;
    cif.rf_wen     = 1'b0;
    cif.wb_sel     = wb_alu;
    cif.alu_fn     = alu_add;
    cif.alu_imm    = 1'b0;
    cif.dmsg_en    = 1'b0;
    cif.mngr_in_en = 1'b0;
    from_mngr_rdy  = 1'b0;
    to_mngr_val    = 1'b0;

    case (state)
      st_fetch:
      begin
        imem.req_val = 1'b1;
        if (imem.req_rdy)
          state_next = st_fetch_wait;
      end
      st_fetch_wait:
      begin
        imem.resp_rdy = 1'b1;
        cif.ir_en     = imem.resp_val;
        if (imem.resp_val)
          state_next = st_exec;
      end
      st_exec:
      begin
        // default path retires the instruction here
        state_next = st_fetch;
        cif.pc_en  = 1'b1;
        case (cif.opcode)
          op_addu, op_subu, op_and:
          begin
            cif.rf_wen = 1'b1;
            if (cif.opcode == op_subu)
              cif.alu_fn = alu_sub;
            else if (cif.opcode == op_and)
              cif.alu_fn = alu_and;
          end
          op_addiu:
          begin
            cif.rf_wen  = 1'b1;
            cif.alu_imm = 1'b1;
          end
          op_lw, op_sw:
          begin
            // latch address and store data, retire after the response
            cif.pc_en   = 1'b0;
            cif.alu_imm = 1'b1;
            cif.dmsg_en = 1'b1;
            state_next  = st_dmem;
          end
          op_bne:
            cif.pc_sel_br = cif.br_taken;
          op_mfc0:
          begin
            cif.pc_en  = mngr_got;
            cif.rf_wen = mngr_got;
            cif.wb_sel = wb_mngr;
            if (!mngr_got)
              state_next = st_mngr_in;
          end
          op_mtc0:
          begin
            cif.pc_en  = 1'b0;
            state_next = st_mngr_out;
          end
          default:
            ;
        endcase
      end
      st_dmem:
      begin
        dmem.req_val = 1'b1;
        if (dmem.req_rdy)
          state_next = st_dmem_wait;
      end
      st_dmem_wait:
      begin
        dmem.resp_rdy = 1'b1;
        cif.wb_sel    = wb_mem;
        cif.pc_en     = dmem.resp_val;
        cif.rf_wen    = dmem.resp_val & (cif.opcode == op_lw);
        if (dmem.resp_val)
          state_next = st_fetch;
      end
      st_mngr_in:
      begin
        // capture the word, write it back from st_exec
        from_mngr_rdy  = 1'b1;
        cif.mngr_in_en = from_mngr_val;
        if (from_mngr_val)
          state_next = st_exec;
      end
      st_mngr_out:
      begin
        to_mngr_val = 1'b1;
        cif.pc_en   = to_mngr_rdy;
        if (to_mngr_rdy)
          state_next = st_fetch;
      end
      default:
        state_next = st_fetch;
    endcase
  end

  // ------------------------------
  // checks
  // ------------------------------
  // input channel opens only for an mfc0 still waiting on its word
  a_mngr_rdy_state: assert property (@(posedge clk) disable iff (!rst_n)
    from_mngr_rdy |-> ((cif.opcode == op_mfc0) && !mngr_got));

  // to-manager message may not be withdrawn before it is taken
  a_to_mngr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (to_mngr_val && !to_mngr_rdy) |=> to_mngr_val);

endmodule

// File: rtl/proc_dpath.sv
/*
 core datapath with PC, instruction register, register file, ALU, branch
 target and the memory and manager message registers; steered by proc_ctrl
*/
`timescale 1ns/1ps

module proc_dpath import proc_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  mem_if.dpath              imem,
  mem_if.dpath              dmem,
  ctrl_if.dpath             cif,
  input  logic [c_xlen-1:0] from_mngr_msg,
  output logic [c_xlen-1:0] to_mngr_msg
);

  logic [c_xlen-1:0]  pc;
  logic [c_xlen-1:0]  ir;
  logic [c_xlen-1:0]  pc_plus4;
  logic [c_xlen-1:0]  br_target;
  logic [c_xlen-1:0]  imm_sext;
  logic [c_xlen-1:0]  rs_val;
  logic [c_xlen-1:0]  rt_val;
  logic [c_xlen-1:0]  alu_b;
  logic [c_xlen-1:0]  alu_out;
  logic [c_xlen-1:0]  wb_data;
  logic [c_xlen-1:0]  mngr_reg;
  logic [c_xlen-1:0]  dreq_addr;
  logic [c_xlen-1:0]  dreq_data;
  logic [c_rf_aw-1:0] ir_rs;
  logic [c_rf_aw-1:0] ir_rt;
  logic [c_rf_aw-1:0] rf_waddr;
  logic [c_xlen-1:0]  rf [c_nregs];

  // ------------------------------
  // fetch side
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc <= c_reset_vector;
      ir <= '0;
    end
    else
    begin
      if (cif.pc_en)
        pc <= cif.pc_sel_br ? br_target : pc_plus4;
      if (cif.ir_en)
        ir <= imem.resp_data;
    end
  end

  assign imem.req_addr = pc;
  assign imem.req_data = '0;

  // ------------------------------
  // decode and register file
  // ------------------------------
  assign cif.opcode = opcode_e'(ir[c_op_msb:c_op_lsb]);
  assign ir_rs      = ir[c_rs_msb:c_rs_lsb];
  assign ir_rt      = ir[c_rt_msb:c_rt_lsb];
  assign imm_sext   = {{(c_xlen-16){ir[c_imm_msb]}}, ir[c_imm_msb:c_imm_lsb]};

  // r-type writes rd, immediate forms write rt
  assign rf_waddr = (cif.opcode inside {op_addu, op_subu, op_and}) ?
                    ir[c_rd_msb:c_rd_lsb] : ir_rt;

  // register 0 is never read from the array
  assign rs_val = (ir_rs == '0) ? '0 : rf[ir_rs];
  assign rt_val = (ir_rt == '0) ? '0 : rf[ir_rt];

  always_ff @(posedge clk)
  begin
    if (cif.rf_wen)
      rf[rf_waddr] <= wb_data;
  end

  // ------------------------------
  // ALU, branch and write-back
  // ------------------------------
  assign alu_b = cif.alu_imm ? imm_sext : rt_val;

  always_comb
  begin
    case (cif.alu_fn)
      alu_sub: alu_out = rs_val - alu_b;
      alu_and: alu_out = rs_val & alu_b;
      default: alu_out = rs_val + alu_b;
    endcase
  end

  assign pc_plus4     = pc + 32'd4;
  assign br_target    = pc_plus4 + {imm_sext[c_xlen-3:0], 2'b00};
  assign cif.br_taken = (rs_val != rt_val);

  always_comb
  begin
    case (cif.wb_sel)
      wb_mem:  wb_data = dmem.resp_data;
      wb_mngr: wb_data = mngr_reg;
      default: wb_data = alu_out;
    endcase
  end

  // ------------------------------
  // message registers
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (cif.dmsg_en)
    begin
      dreq_addr <= alu_out;
      dreq_data <= rt_val;
    end
    if (cif.mngr_in_en)
      mngr_reg <= from_mngr_msg;
  end

  assign dmem.req_addr = dreq_addr;
  assign dmem.req_data = dreq_data;
  // mtc0 sends rt
  assign to_mngr_msg   = rt_val;

  // an immediate added to register 0 leaves the ALU unchanged
  a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    ((ir_rs == '0) && cif.alu_imm && (cif.alu_fn == alu_add)) |-> (alu_out == imm_sext));

endmodule

// File: rtl/mem_2port.sv
/*
 word memory with two val/rdy ports of fixed one-cycle latency
 the load port fills it during reset
*/
`timescale 1ns/1ps

module mem_2port import proc_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  mem_if.mem                  port0,
  mem_if.mem                  port1,
  input  logic                load_en,
  input  logic [c_mem_aw-1:0] load_addr,
  input  logic [c_xlen-1:0]   load_data
);

  logic [c_xlen-1:0]   mem [c_mem_nwords];

  // both ports gathered into arrays, index 0 is port0
  logic [1:0]          req_val;
  logic [1:0]          req_rdy;
  logic [1:0]          req_wr;
  logic [1:0]          resp_val;
  logic [1:0]          resp_rdy;
  logic [1:0]          xfer;
  logic [c_mem_aw-1:0] req_idx [2];
  logic [c_xlen-1:0]   req_data [2];
  logic [c_xlen-1:0]   resp_data [2];

  assign req_val     = {port1.req_val, port0.req_val};
  assign req_wr      = {port1.req_type == mem_wr, port0.req_type == mem_wr};
  assign resp_rdy    = {port1.resp_rdy, port0.resp_rdy};
  // byte address to word index
  assign req_idx[0]  = port0.req_addr[c_mem_aw+1:2];
  assign req_idx[1]  = port1.req_addr[c_mem_aw+1:2];
  assign req_data[0] = port0.req_data;
  assign req_data[1] = port1.req_data;

  // one item in flight per port
  assign req_rdy = ~resp_val;
  assign xfer    = req_val & req_rdy;

  assign port0.req_rdy   = req_rdy[0];
  assign port1.req_rdy   = req_rdy[1];
  assign port0.resp_val  = resp_val[0];
  assign port1.resp_val  = resp_val[1];
  assign port0.resp_data = resp_data[0];
  assign port1.resp_data = resp_data[1];

  // response slot fills on accept, drains when taken
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      resp_val <= '0;
    else
      resp_val <= xfer | (resp_val & ~resp_rdy);
  end

  always_ff @(posedge clk)
  begin
    if (load_en)
      mem[load_addr] <= load_data;
    for (int p = 0; p < 2; p++)
    begin
      if (xfer[p] && req_wr[p])
        mem[req_idx[p]] <= req_data[p];
      if (xfer[p])
        resp_data[p] <= req_wr[p] ? '0 : mem[req_idx[p]];
    end
  end

  // waiting responses stay put until taken
  for (genvar p = 0; p < 2; p++)
  begin : g_chk
    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_val[p] && !resp_rdy[p]) |=> (resp_val[p] && $stable(resp_data[p])));
  end

endmodule

// File: rtl/proc_sys_top.sv
/*
 processor subsystem, core plus two-port memory with plain manager ports
 and a word load port for use while rst_n is low
*/
`timescale 1ns/1ps

module proc_sys_top import proc_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  // memory image load
  input  logic                mem_load_en,
  input  logic [c_mem_aw-1:0] mem_load_addr,
  input  logic [c_xlen-1:0]   mem_load_data,
  // from manager
  input  logic                from_mngr_val,
  input  logic [c_xlen-1:0]   from_mngr_msg,
  output logic                from_mngr_rdy,
  // to manager
  output logic                to_mngr_val,
  output logic [c_xlen-1:0]   to_mngr_msg,
  input  logic                to_mngr_rdy
);

  // instruction port is port0, data port is port1
  mem_if  imem ();
  mem_if  dmem ();
  ctrl_if cif ();

  proc_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem          (imem.ctrl),
    .dmem          (dmem.ctrl),
    .cif           (cif.ctrl),
    .from_mngr_val (from_mngr_val),
    .from_mngr_rdy (from_mngr_rdy),
    .to_mngr_val   (to_mngr_val),
    .to_mngr_rdy   (to_mngr_rdy)
  );

  proc_dpath u_dpath (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem          (imem.dpath),
    .dmem          (dmem.dpath),
    .cif           (cif.dpath),
    .from_mngr_msg (from_mngr_msg),
    .to_mngr_msg   (to_mngr_msg)
  );

  mem_2port u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .port0     (imem.mem),
    .port1     (dmem.mem),
    .load_en   (mem_load_en),
    .load_addr (mem_load_addr),
    .load_data (mem_load_data)
  );

endmodule

// File: bench/tb_clock.sv
/*
 clock and reset source for the testbench, 10 ns period
 rst_n stays low for 8 cycles after start and after rst_req drops
*/
`timescale 1ns/1ps

module tb_clock (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);

  // rising edges still to go before release
  int hold;

  initial
  begin
    clk   = 1'b0;
    rst_n <= 1'b0;
    hold  <= 8;
  end

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    if (rst_req)
      hold <= 8;
    else if (hold != 0)
      hold <= hold - 1;
  end

  // reset moves on the falling edge, away from the DUT's edge
  always @(negedge clk)
    rst_n <= (hold == 0);

endmodule

// File: bench/proc_sys_tb.sv
/*
 testbench for the processor subsystem: random programs run on the DUT and on
 an instruction-level model, to-manager words are compared in order
*/
`timescale 1ns/1ps

module proc_sys_tb import proc_pkg::*; ();

  logic                clk;
  logic                rst_n;
  logic                rst_req;
  logic                mem_load_en;
  logic [c_mem_aw-1:0] mem_load_addr;
  logic [c_xlen-1:0]   mem_load_data;
  logic                from_mngr_val;
  logic [c_xlen-1:0]   from_mngr_msg;
  logic                from_mngr_rdy;
  logic                to_mngr_val;
  logic [c_xlen-1:0]   to_mngr_msg;
  logic                to_mngr_rdy;

  integer      seed;
  logic [31:0] rnd;
  int          cycles;
  int          limit;
  int          checks;
  int          errors;
  int          tests;
  // random back-pressure on both manager channels
  bit          bp;
  // a from-manager word goes across at the coming rising edge
  bit          in_taken;

  // program image, manager input words and model output
  logic [31:0] prog [$];
  logic [31:0] from_words [$];
  logic [31:0] exp_words [$];
  // live copies used up by the channel driver
  logic [31:0] from_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] model_rf [32];
  logic [31:0] model_dm [int];

  tb_clock u_clock (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

  proc_sys_top u_proc_sys_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_load_en   (mem_load_en),
    .mem_load_addr (mem_load_addr),
    .mem_load_data (mem_load_data),
    .from_mngr_val (from_mngr_val),
    .from_mngr_msg (from_mngr_msg),
    .from_mngr_rdy (from_mngr_rdy),
    .to_mngr_val   (to_mngr_val),
    .to_mngr_msg   (to_mngr_msg),
    .to_mngr_rdy   (to_mngr_rdy)
  );

  function automatic int pick(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic logic [31:0] encode_r(opcode_e op, int rd, int rs, int rt);
    return {op, rs[4:0], rt[4:0], rd[4:0], 11'b0};
  endfunction

  function automatic logic [31:0] encode_i(opcode_e op, int rt, int rs, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // ------------------------------
  // program builder
  // ------------------------------
  task automatic build_program(input int kind);
    int          offs [4];
    logic [31:0] word;
    prog.delete();
    from_words.delete();
    case (kind)
      1:
      begin
        // seed every register, random ALU ops, then dump all 32
        for (int r = 1; r < 32; r++)
          prog.push_back(encode_i(op_addiu, r, 0, pick(65536)));
        for (int i = 0; i < 24; i++)
        begin
          case (pick(4))
            0: prog.push_back(encode_r(op_addu, pick(32), pick(32), pick(32)));
            1: prog.push_back(encode_r(op_subu, pick(32), pick(32), pick(32)));
            2: prog.push_back(encode_r(op_and, pick(32), pick(32), pick(32)));
            default: prog.push_back(encode_i(op_addiu, pick(32), pick(32), pick(65536)));
          endcase
        end
        for (int r = 0; r < 32; r++)
          prog.push_back(encode_i(op_mtc0, r, 0, 0));
      end
      2:
      begin
        // echo each captured word, then send a sum of two
        for (int i = 0; i < 4; i++)
        begin
          word = $random(seed);
          from_words.push_back(word);
          prog.push_back(encode_i(op_mfc0, 1 + i, 0, 0));
          prog.push_back(encode_i(op_mtc0, 1 + i, 0, 0));
        end
        prog.push_back(encode_r(op_addu, 10, 1 + pick(4), 1 + pick(4)));
        prog.push_back(encode_i(op_mtc0, 10, 0, 0));
      end
      3:
      begin
        // base 0x2040 so offsets reach both sides of it
        prog.push_back(encode_i(op_addiu, 1, 0, 32'h2040));
        for (int i = 0; i < 4; i++)
        begin
          offs[i] = (pick(32) - 16) * 4;
          prog.push_back(encode_i(op_addiu, 2 + i, 0, pick(65536)));
          prog.push_back(encode_i(op_sw, 2 + i, 1, offs[i]));
        end
        for (int i = 0; i < 4; i++)
        begin
          prog.push_back(encode_i(op_lw, 10 + i, 1, offs[i]));
          prog.push_back(encode_i(op_mtc0, 10 + i, 0, 0));
        end
      end
      default:
      begin
        // countdown from 1..8, r2 collects the sum
        prog.push_back(encode_i(op_addiu, 1, 0, 1 + pick(8)));
        prog.push_back(encode_i(op_addiu, 2, 0, 0));
        prog.push_back(encode_r(op_addu, 2, 2, 1));
        prog.push_back(encode_i(op_addiu, 1, 1, -1));
        prog.push_back(encode_i(op_bne, 0, 1, -3));
        prog.push_back(encode_i(op_mtc0, 2, 0, 0));
        // marker word shows the loop fell through
        prog.push_back(encode_i(op_addiu, 3, 0, 32'h0a5a));
        prog.push_back(encode_i(op_mtc0, 3, 0, 0));
      end
    endcase
    // unused opcode runs as a nop, then a self loop parks the core
    prog.push_back(32'hfc00_0000);
    prog.push_back(encode_i(op_addiu, 1, 0, 1));
    prog.push_back(encode_i(op_bne, 0, 1, -1));
  endtask

  // ------------------------------
  // instruction-level model
  // ------------------------------
  task automatic run_model(output int steps);
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] imm;
    logic [31:0] nxt;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    int          idx;
    int          fi;
    bit          halt;
    for (int r = 0; r < 32; r++)
      model_rf[r] = '0;
    model_dm.delete();
    exp_words.delete();
    pc    = c_reset_vector;
    steps = 0;
    fi    = 0;
    halt  = 1'b0;
    while (!halt && steps < 4000)
    begin
      idx = int'((pc - c_reset_vector) >> 2);
      if (idx >= prog.size())
        halt = 1'b1;
      else
      begin
        w   = prog[idx];
        rs  = w[25:21];
        rt  = w[20:16];
        rd  = w[15:11];
        imm = {{16{w[15]}}, w[15:0]};
        nxt = pc + 32'd4;
        case (w[31:26])
          op_addu:  model_rf[rd] = model_rf[rs] + model_rf[rt];
          op_subu:  model_rf[rd] = model_rf[rs] - model_rf[rt];
          op_and:   model_rf[rd] = model_rf[rs] & model_rf[rt];
          op_addiu: model_rf[rt] = model_rf[rs] + imm;
          op_lw:    model_rf[rt] = model_dm[int'((model_rf[rs] + imm) >> 2)];
          op_sw:    model_dm[int'((model_rf[rs] + imm) >> 2)] = model_rf[rt];
          op_bne:
          begin
            if (model_rf[rs] != model_rf[rt])
              nxt = pc + 32'd4 + (imm << 2);
            // a taken branch onto itself ends the program
            halt = (nxt == pc);
          end
          op_mfc0:
          begin
            model_rf[rt] = from_words[fi];
            fi++;
          end
          op_mtc0:  exp_words.push_back(model_rf[rt]);
          default:  ;
        endcase
        model_rf[0] = '0;
        pc = nxt;
        steps++;
      end
    end
  endtask

  // ------------------------------
  // test sequencing
  // ------------------------------
  task automatic start_run(input bit pressure);
    from_q  = from_words;
    exp_q   = exp_words;
    bp      = pressure;
    rst_req = 1'b0;
  endtask

  task automatic run_test(input int kind, input bit pressure, input bit mid_reset);
    int                  steps;
    int                  stop_at;
    int                  errs_at_start;
    logic [c_mem_aw-1:0] addr;
    build_program(kind);
    run_model(steps);
    limit         = limit + steps * 40;
    errs_at_start = errors;
    rst_req       = 1'b1;
    @(negedge clk);
    @(negedge clk);
    // image goes in while the core is held in reset
    addr = c_reset_vector[c_mem_aw+1:2];
    foreach (prog[i])
    begin
      mem_load_en   = 1'b1;
      mem_load_addr = addr;
      mem_load_data = prog[i];
      addr          = addr + 12'd1;
      @(negedge clk);
    end
    mem_load_en = 1'b0;
    if (mid_reset)
    begin
      start_run(1'b0);
      // let a few words out, then pull reset in the middle of the program
      stop_at = exp_q.size() - 1 - pick(8);
      while (exp_q.size() > stop_at)
        @(negedge clk);
      rst_req = 1'b1;
      @(negedge clk);
      @(negedge clk);
    end
    start_run(pressure);
    while (exp_q.size() != 0)
      @(negedge clk);
    // quiet window, any extra word shows up as unexpected
    repeat (20) @(negedge clk);
    tests++;
    $display("test %0d kind %0d back_pressure %0b mid_reset %0b words %0d steps %0d: %s",
             tests, kind, pressure, mid_reset, exp_words.size(), steps,
             (errors == errs_at_start) ? "ok" : "failed");
  endtask

  // manager channels, driven on the falling edge and sampled once settled
  always @(negedge clk)
  begin
    if (in_taken)
      void'(from_q.pop_front());
    from_mngr_val = (from_q.size() != 0) && (!bp || rnd[0]);
    from_mngr_msg = (from_q.size() != 0) ? from_q[0] : '0;
    to_mngr_rdy   = !bp || rnd[1];
    #1;
    in_taken = rst_n && from_mngr_val && from_mngr_rdy;
    // no mfc0 is left to run once every input word is used up
    if (rst_n && (from_q.size() == 0))
      check_value("from_mngr_rdy", 32'd0, {31'd0, from_mngr_rdy});
    if (rst_n && to_mngr_val && to_mngr_rdy)
    begin
      if (exp_q.size() == 0)
      begin
        $display("unexpected to_mngr word %h after the last expected word", to_mngr_msg);
        errors++;
      end
      else
        check_value("to_mngr_msg", exp_q.pop_front(), to_mngr_msg);
    end
    // back-pressure bits for the next cycle
    rnd = $random(seed);
  end

  // cycle budget grows with each test's model length
  always @(negedge clk)
  begin
    if (rst_n)
      cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("timeout: the processor stopped producing output after %0d cycles", cycles);
      $display("%0d expected words were never received", exp_q.size());
      $display("Done: errors found");
      $finish;
    end
  end

  initial
  begin
    seed          = 49112;
    rnd           = '0;
    rst_req       = 1'b1;
    mem_load_en   = 1'b0;
    mem_load_addr = '0;
    mem_load_data = '0;
    from_mngr_val = 1'b0;
    from_mngr_msg = '0;
    to_mngr_rdy   = 1'b0;
    cycles        = 0;
    limit         = 0;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    bp            = 1'b0;
    in_taken      = 1'b0;
    @(negedge clk);
    for (int k = 1; k <= 4; k++)
      run_test(k, 1'b0, 1'b0);
    for (int k = 1; k <= 4; k++)
      run_test(k, 1'b1, 1'b0);
    run_test(1, 1'b0, 1'b1);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: proc_sys.f
rtl/proc_pkg.sv
rtl/mem_if.sv
rtl/ctrl_if.sv
rtl/proc_ctrl.sv
rtl/proc_dpath.sv
rtl/mem_2port.sv
rtl/proc_sys_top.sv
bench/tb_clock.sv
bench/proc_sys_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then judge the run from sim.log
verilator --binary --assert --top-module proc_sys_tb -f proc_sys.f -o sim_proc_sys \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_proc_sys > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL, run did not finish"; exit 1; }
